// ==== sim.f ====
mdp_pkg.sv
bram_1rport_1wport.sv
mdpt.sv
mdpt_decay_timer.sv
mdpt_clear_ctrl.sv
mdp_predictor_top.sv
tb_mdp_predictor.sv

// ==== Makefile ====
TOP := tb_mdp_predictor

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== tb_mdp_predictor.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mdp_predictor import mdp_pkg::*; ();

    localparam int WAIT_LIMIT    = 2000;
    localparam int PC_UPPER_BITS = PC_BITS - LANE_BITS - MDPT_IDX_BITS;

    typedef logic [PC_UPPER_BITS-1:0] pc_upper_t;

    logic       CLK;
    logic       reset;
    asid_t      arch_asid;
    logic       read_req_valid;
    fetch_idx_t read_req_fetch_index;
    mdpt_set_t  read_resp_mdp_by_lane;
    logic       update_valid;
    pc38_t      update_pc38;
    mdp_t       update_mdp;
    logic       clearing;

    // shadow of the table, indexed by hashed set
    mdpt_set_t   shadow [MDPT_SETS];
    logic [31:0] lfsr_state = 32'h6a3e_2c50;

    int   pass_count;
    int   fail_count;
    int   test_fails;
    logic timed_out;

    // length of the last completed clearing run
    int high_run;
    int last_sweep_len;

    mdp_predictor_top DUT (
        .CLK                   (CLK),
        .reset                 (reset),
        .arch_asid             (arch_asid),
        .read_req_valid        (read_req_valid),
        .read_req_fetch_index  (read_req_fetch_index),
        .read_resp_mdp_by_lane (read_resp_mdp_by_lane),
        .update_valid          (update_valid),
        .update_pc38           (update_pc38),
        .update_mdp            (update_mdp),
        .clearing              (clearing)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        if (clearing) begin
            high_run <= high_run + 1;
        end else if (high_run != 0) begin
            last_sweep_len <= high_run;
            high_run       <= 0;
        end
    end

    // ----------------------------------------
    // helpers
    // ----------------------------------------

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // set index = fetch index xor low asid bits
    function automatic mdpt_idx_t set_of(fetch_idx_t f, asid_t a);
        return f ^ a[MDPT_IDX_BITS-1:0];
    endfunction

    // upper pc bits are random and must not matter
    function automatic pc38_t make_pc(fetch_idx_t f, fetch_lane_t l);
        pc_upper_t upper;
        upper = pc_upper_t'(take_bits(PC_UPPER_BITS));
        return {upper, f, l};
    endfunction

    task automatic check_value(string name, mdpt_set_t expected, mdpt_set_t actual);
        assert (actual === expected) begin
            pass_count++;
        end else begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            fail_count++;
            test_fails++;
        end
    endtask

    task automatic finish_test(string name);
        if (test_fails == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_fails);
        end
        test_fails = 0;
    endtask

    task automatic read_and_check(string name, fetch_idx_t f, mdpt_set_t expected);
        @(posedge CLK);
        read_req_valid       <= 1'b1;
        read_req_fetch_index <= f;
        @(posedge CLK);
        read_req_valid       <= 1'b0;
        @(negedge CLK);
        check_value(name, expected, read_resp_mdp_by_lane);
    endtask

    task automatic send_update(fetch_idx_t f, fetch_lane_t l, mdp_t v);
        mdpt_idx_t s;
        int        lsb;
        s   = set_of(f, arch_asid);
        lsb = int'(l) * MDP_BITS;
        @(posedge CLK);
        update_valid <= 1'b1;
        update_pc38  <= make_pc(f, l);
        update_mdp   <= v;
        @(negedge CLK);
        // only forwarded while the controller is idle
        if (!clearing) begin
            shadow[s][lsb +: MDP_BITS] = v;
        end
        @(posedge CLK);
        update_valid <= 1'b0;
    endtask

    task automatic wait_clearing(logic level, string name);
        int cycles;
        cycles = 0;
        @(negedge CLK);
        while (clearing !== level && cycles < WAIT_LIMIT) begin
            @(negedge CLK);
            cycles++;
        end
        if (clearing !== level) begin
            $display("%s: clearing did not go %0s within %0d cycles",
                     name, level ? "high" : "low", WAIT_LIMIT);
            timed_out = 1'b1;
            fail_count++;
            test_fails++;
        end else if (!level) begin
            // finished sweep leaves every set at zero
            foreach (shadow[i]) shadow[i] = '0;
        end
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------

    task automatic test_reset_clear();
        fetch_idx_t f;
        wait_clearing(1'b1, "reset_clear");
        if (!timed_out) begin
            wait_clearing(1'b0, "reset_clear");
        end
        if (!timed_out) begin
            for (int i = 0; i < 16; i++) begin
                f = fetch_idx_t'(take_bits(MDPT_IDX_BITS));
                read_and_check("reset_clear", f, '0);
            end
        end
        finish_test("reset_clear");
    endtask

    task automatic test_single_lane();
        fetch_idx_t  f;
        fetch_lane_t l;
        mdp_t        v;
        for (int i = 0; i < 8; i++) begin
            f = fetch_idx_t'(take_bits(MDPT_IDX_BITS));
            l = fetch_lane_t'(take_bits(LANE_BITS));
            v = mdp_t'(take_bits(MDP_BITS));
            send_update(f, l, v);
            read_and_check("single_lane", f, shadow[set_of(f, arch_asid)]);
        end
        finish_test("single_lane");
    endtask

    task automatic test_lane_merge();
        fetch_idx_t  f;
        fetch_lane_t l;
        mdp_t        base;
        mdp_t        v;
        f    = fetch_idx_t'(take_bits(MDPT_IDX_BITS));
        base = mdp_t'(take_bits(MDP_BITS));
        // distinct value per lane
        for (int lane = 0; lane < FETCH_LANES; lane++) begin
            v = base ^ mdp_t'(8'h11 * (lane + 1));
            send_update(f, fetch_lane_t'(lane), v);
        end
        read_and_check("lane_merge", f, shadow[set_of(f, arch_asid)]);
        l = fetch_lane_t'(take_bits(LANE_BITS));
        v = shadow[set_of(f, arch_asid)][int'(l)*MDP_BITS +: MDP_BITS] ^ 8'hff;
        send_update(f, l, v);
        read_and_check("lane_merge", f, shadow[set_of(f, arch_asid)]);
        finish_test("lane_merge");
    endtask

    task automatic test_asid_hash();
        fetch_idx_t  f;
        fetch_idx_t  g;
        fetch_lane_t l;
        mdp_t        v;
        asid_t       a1;
        mdpt_idx_t   s;
        f = fetch_idx_t'(take_bits(MDPT_IDX_BITS));
        l = fetch_lane_t'(take_bits(LANE_BITS));
        v = mdp_t'(take_bits(MDP_BITS)) | 8'h01;
        send_update(f, l, v);
        s  = set_of(f, arch_asid);
        a1 = asid_t'(take_bits(ASID_BITS));
        if (a1[MDPT_IDX_BITS-1:0] == arch_asid[MDPT_IDX_BITS-1:0]) begin
            a1[0] = ~a1[0];
        end
        @(posedge CLK);
        arch_asid <= a1;
        @(negedge CLK);
        // fetch index that lands on the written set under the new asid
        g = s ^ a1[MDPT_IDX_BITS-1:0];
        read_and_check("asid_hash", g, shadow[s]);
        read_and_check("asid_hash", f, shadow[set_of(f, arch_asid)]);
        finish_test("asid_hash");
    endtask

    task automatic test_decay();
        fetch_idx_t  f;
        fetch_lane_t l;
        int          cycles;
        cycles = 0;
        wait_clearing(1'b1, "decay");
        if (!timed_out) begin
            // sweep slot of a pc is fetch index times lanes plus lane
            while (clearing === 1'b1 && high_run < CLEAR_LEN / 2 && cycles < WAIT_LIMIT) begin
                @(negedge CLK);
                cycles++;
            end
            if (high_run < CLEAR_LEN / 2) begin
                $display("decay: sweep ended or stalled before its second half");
                timed_out = 1'b1;
                fail_count++;
                test_fails++;
            end
        end
        if (!timed_out) begin
            // low fetch indices, already swept, so only dropping keeps them at zero
            for (int i = 0; i < 6; i++) begin
                f = fetch_idx_t'(take_bits(MDPT_IDX_BITS - 2));
                l = fetch_lane_t'(take_bits(LANE_BITS));
                send_update(f, l, mdp_t'(take_bits(MDP_BITS)) | 8'h80);
            end
            wait_clearing(1'b0, "decay");
        end
        if (!timed_out) begin
            for (int i = 0; i < MDPT_SETS; i++) begin
                f = fetch_idx_t'(i);
                read_and_check("decay", f, shadow[set_of(f, arch_asid)]);
            end
            check_value("decay_sweep_len", mdpt_set_t'(CLEAR_LEN), mdpt_set_t'(last_sweep_len));
        end
        finish_test("decay");
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------

    initial begin
        reset                <= 1'b1;
        arch_asid            <= asid_t'(take_bits(ASID_BITS));
        read_req_valid       <= 1'b0;
        read_req_fetch_index <= '0;
        update_valid         <= 1'b0;
        update_pc38          <= '0;
        update_mdp           <= '0;
        pass_count = 0;
        fail_count = 0;
        test_fails = 0;
        timed_out  = 1'b0;
        foreach (shadow[i]) shadow[i] = '0;

        repeat (5) @(posedge CLK);
        reset <= 1'b0;

        test_reset_clear();
        if (!timed_out) begin
            test_single_lane();
        end
        if (!timed_out) begin
            test_lane_merge();
        end
        if (!timed_out) begin
            test_asid_hash();
        end
        if (!timed_out) begin
            test_decay();
        end

        $display("checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mdp_predictor_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mdp_predictor_top import mdp_pkg::*; (
    input  logic       CLK,
    input  logic       reset,

    input  asid_t      arch_asid,

    // fetch side
    input  logic       read_req_valid,
    input  fetch_idx_t read_req_fetch_index,
    output mdpt_set_t  read_resp_mdp_by_lane,

    // back-end side
    input  logic       update_valid,
    input  pc38_t      update_pc38,
    input  mdp_t       update_mdp,

    output logic       clearing
);

    logic  clear_tick;
    logic  tbl_update_valid;
    pc38_t tbl_update_pc38;
    mdp_t  tbl_update_mdp;

    mdpt_decay_timer decay_timer (
        .CLK        (CLK),
        .reset      (reset),
        .clear_tick (clear_tick)
    );

    // controller owns the table update port
    mdpt_clear_ctrl clear_ctrl (
        .CLK              (CLK),
        .reset            (reset),
        .arch_asid        (arch_asid),
        .clear_tick       (clear_tick),
        .update_valid     (update_valid),
        .update_pc38      (update_pc38),
        .update_mdp       (update_mdp),
        .clearing         (clearing),
        .tbl_update_valid (tbl_update_valid),
        .tbl_update_pc38  (tbl_update_pc38),
        .tbl_update_mdp   (tbl_update_mdp)
    );

    mdpt mdpt_table (
        .CLK                   (CLK),
        .reset                 (reset),
        .arch_asid             (arch_asid),
        .read_req_valid        (read_req_valid),
        .read_req_fetch_index  (read_req_fetch_index),
        .read_resp_mdp_by_lane (read_resp_mdp_by_lane),
        .update_valid          (tbl_update_valid),
        .update_pc38           (tbl_update_pc38),
        .update_mdp            (tbl_update_mdp)
    );

endmodule

`default_nettype wire

// ==== mdpt_clear_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module mdpt_clear_ctrl import mdp_pkg::*; (
    input  logic  CLK,
    input  logic  reset,

    // hash key, must hold during a sweep
    input  asid_t arch_asid,

    // periodic request from the decay timer
    input  logic  clear_tick,

    // back-end training
    input  logic  update_valid,
    input  pc38_t update_pc38,
    input  mdp_t  update_mdp,

    // sweep status
    output logic  clearing,

    // table update port
    output logic  tbl_update_valid,
    output pc38_t tbl_update_pc38,
    output mdp_t  tbl_update_mdp
);

    localparam sweep_cnt_t SWEEP_LAST = sweep_cnt_t'(CLEAR_LEN - 1);

    clear_state_t state;
    clear_state_t state_next;
    sweep_cnt_t   sweep_cnt;
    sweep_cnt_t   sweep_cnt_next;
    pc38_t        sweep_pc;

    // ----------------------------------------
    // state machine
    // ----------------------------------------

    always_comb begin
        state_next     = state;
        sweep_cnt_next = sweep_cnt;

        case (state)
            CLR_IDLE: begin
                if (clear_tick) begin
                    state_next     = CLR_SWEEP;
                    sweep_cnt_next = '0;
                end
            end
            CLR_SWEEP: begin
                // ticks arriving here are ignored
                if (sweep_cnt == SWEEP_LAST) begin
                    state_next     = CLR_IDLE;
                    sweep_cnt_next = '0;
                end else begin
                    sweep_cnt_next = sweep_cnt + sweep_cnt_t'(1);
                end
            end
            default: begin
                state_next     = CLR_IDLE;
                sweep_cnt_next = '0;
            end
        endcase
    end

    // coming out of reset always clears the table
    always_ff @(posedge CLK) begin
        if (reset) begin
            state     <= CLR_SWEEP;
            sweep_cnt <= '0;
        end else begin
            state     <= state_next;
            sweep_cnt <= sweep_cnt_next;
        end
    end

    assign clearing = (state == CLR_SWEEP);

    // ----------------------------------------
    // update port mux
    // ----------------------------------------

    // upper counter bits are the fetch index, lower bits the lane
    always_comb begin
        sweep_pc = '0;
        sweep_pc[LANE_BITS-1:0] = sweep_cnt[LANE_BITS-1:0];
        sweep_pc[LANE_BITS +: MDPT_IDX_BITS] = sweep_cnt[SWEEP_CNT_BITS-1 -: MDPT_IDX_BITS];
    end

    // back-end updates are dropped while sweeping
    assign tbl_update_valid = clearing ? 1'b1     : update_valid;
    assign tbl_update_pc38  = clearing ? sweep_pc : update_pc38;
    assign tbl_update_mdp   = clearing ? '0       : update_mdp;

    // ----------------------------------------
    // checks
    // ----------------------------------------

    // a changed asid would remap sets mid sweep and skip some
    a_asid_stable: assert property (@(posedge CLK) disable iff (reset)
        clearing ##1 clearing |-> $stable(arch_asid));

    a_sweep_zero: assert property (@(posedge CLK) disable iff (reset)
        (clearing && tbl_update_valid) |-> (tbl_update_mdp == '0));

endmodule

`default_nettype wire

// ==== mdpt_decay_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module mdpt_decay_timer import mdp_pkg::*; (
    input  logic CLK,
    input  logic reset,

    // one cycle pulse per interval
    output logic clear_tick
);

    localparam decay_cnt_t TERMINAL = decay_cnt_t'(CLEAR_PERIOD - 1);

    decay_cnt_t count;

    // ----------------------------------------
    // interval counter
    // ----------------------------------------

    always_ff @(posedge CLK) begin
        if (reset) begin
            count <= '0;
        end else if (count == TERMINAL) begin
            count <= '0;
        end else begin
            count <= count + decay_cnt_t'(1);
        end
    end

    // tick on the terminal value, counter wraps after it
    assign clear_tick = (count == TERMINAL);

    // the wrap keeps ticks a full period apart
    a_tick_single: assert property (@(posedge CLK) disable iff (reset)
        clear_tick |=> !clear_tick);

endmodule

`default_nettype wire

// ==== mdpt.sv ====
`timescale 1ns/1ps
`default_nettype none

module mdpt import mdp_pkg::*; (
    input  logic       CLK,
    input  logic       reset,

    // current address space
    input  asid_t      arch_asid,

    // read request, response next cycle
    input  logic       read_req_valid,
    input  fetch_idx_t read_req_fetch_index,
    output mdpt_set_t  read_resp_mdp_by_lane,

    // single lane training
    input  logic       update_valid,
    input  pc38_t      update_pc38,
    input  mdp_t       update_mdp
);

    // low fetch index bits xor low asid bits
    function automatic mdpt_idx_t index_hash(fetch_idx_t fetch_index, asid_t asid);
        return mdpt_idx_t'(fetch_index ^ asid[MDPT_IDX_BITS-1:0]);
    endfunction

    // ----------------------------------------
    // signals
    // ----------------------------------------

    mdpt_idx_t                  bram_rindex;
    mdpt_set_t                  bram_rdata;

    logic [FETCH_LANES-1:0]     lane_wen;
    logic [SET_BYTES-1:0]       bram_wen_byte;
    mdpt_idx_t                  bram_windex;
    mdpt_set_t                  bram_wdata;

    fetch_lane_t                update_lane;

    // ----------------------------------------
    // read path
    // ----------------------------------------

    assign bram_rindex           = index_hash(read_req_fetch_index, arch_asid);
    assign read_resp_mdp_by_lane = bram_rdata;

    // ----------------------------------------
    // write path
    // ----------------------------------------

    always_comb begin
        update_lane = fetch_lane_bits(update_pc38);
        bram_windex = index_hash(fetch_idx_bits(update_pc38), arch_asid);

        lane_wen = '0;
        if (update_valid) begin
            lane_wen[update_lane] = 1'b1;
        end

        // byte enables pick the lane, data is copied to all of them
        for (int lane = 0; lane < FETCH_LANES; lane++) begin
            bram_wen_byte[lane*MDP_BYTES +: MDP_BYTES] = {MDP_BYTES{lane_wen[lane]}};
            bram_wdata[lane*MDP_BITS +: MDP_BITS]      = update_mdp;
        end
    end

    bram_1rport_1wport #(
        .INNER_WIDTH($bits(mdpt_set_t)),
        .OUTER_WIDTH(MDPT_SETS)
    ) mdpt_array_bram (
        .CLK      (CLK),
        .reset    (reset),
        .ren      (read_req_valid),
        .rindex   (bram_rindex),
        .rdata    (bram_rdata),
        .wen_byte (bram_wen_byte),
        .windex   (bram_windex),
        .wdata    (bram_wdata)
    );

    a_lane_wen_onehot: assert property (@(posedge CLK) disable iff (reset)
        $onehot0(lane_wen));

endmodule

`default_nettype wire

// ==== bram_1rport_1wport.sv ====
`timescale 1ns/1ps
`default_nettype none

module bram_1rport_1wport #(
    parameter int INNER_WIDTH = 32,
    parameter int OUTER_WIDTH = 64
) (
    input  logic                           CLK,
    input  logic                           reset,

    // read port, data one cycle later
    input  logic                           ren,
    input  logic [$clog2(OUTER_WIDTH)-1:0] rindex,
    output logic [INNER_WIDTH-1:0]         rdata,

    // write port, one enable per byte
    input  logic [INNER_WIDTH/8-1:0]       wen_byte,
    input  logic [$clog2(OUTER_WIDTH)-1:0] windex,
    input  logic [INNER_WIDTH-1:0]         wdata
);

    localparam int NUM_BYTES = INNER_WIDTH / 8;

    logic [INNER_WIDTH-1:0] mem [OUTER_WIDTH];

    // ----------------------------------------
    // array writes
    // ----------------------------------------

    always_ff @(posedge CLK) begin
        for (int b = 0; b < NUM_BYTES; b++) begin
            if (wen_byte[b]) begin
                mem[windex][b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
    end

    // read register sees the old word on a same-index write
    always_ff @(posedge CLK) begin
        if (reset) begin
            rdata <= '0;
        end else if (ren) begin
            rdata <= mem[rindex];
        end
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------

    a_rindex_range: assert property (@(posedge CLK) disable iff (reset)
        ren |-> (int'(rindex) < OUTER_WIDTH));

    a_windex_range: assert property (@(posedge CLK) disable iff (reset)
        (|wen_byte) |-> (int'(windex) < OUTER_WIDTH));

endmodule

`default_nettype wire

// ==== mdp_pkg.sv ====
`default_nettype none

package mdp_pkg;

    // ----------------------------------------
    // table geometry
    // ----------------------------------------

    localparam int FETCH_LANES   = 4;
    localparam int LANE_BITS     = 2;
    localparam int MDPT_SETS     = 64;
    localparam int MDPT_IDX_BITS = 6;

    // architectural widths
    localparam int ASID_BITS = 9;
    localparam int PC_BITS   = 38;
    localparam int MDP_BITS  = 8;

    // byte enables per lane and per set
    localparam int MDP_BYTES = MDP_BITS / 8;
    localparam int SET_BYTES = FETCH_LANES * MDP_BYTES;

    // ----------------------------------------
    // decay and sweep
    // ----------------------------------------

    localparam int CLEAR_PERIOD   = 1024;
    localparam int CLEAR_LEN      = MDPT_SETS * FETCH_LANES;
    localparam int DECAY_CNT_BITS = $clog2(CLEAR_PERIOD);
    localparam int SWEEP_CNT_BITS = $clog2(CLEAR_LEN);

    // ----------------------------------------
    // types
    // ----------------------------------------

    typedef logic [ASID_BITS-1:0]      asid_t;
    typedef logic [MDPT_IDX_BITS-1:0]  fetch_idx_t;
    typedef logic [LANE_BITS-1:0]      fetch_lane_t;
    typedef logic [MDPT_IDX_BITS-1:0]  mdpt_idx_t;
    typedef logic [PC_BITS-1:0]        pc38_t;

    // zero means no dependence
    typedef logic [MDP_BITS-1:0]       mdp_t;
    typedef mdp_t                      mdpt_entry_t;

    // lane 0 sits in the low byte
    typedef logic [FETCH_LANES*MDP_BITS-1:0] mdpt_set_t;

    typedef logic [DECAY_CNT_BITS-1:0] decay_cnt_t;
    typedef logic [SWEEP_CNT_BITS-1:0] sweep_cnt_t;

    typedef enum logic {
        CLR_IDLE,
        CLR_SWEEP
    } clear_state_t;

    // pc slicing, halfword granularity
    function automatic fetch_idx_t fetch_idx_bits(pc38_t pc);
        return pc[LANE_BITS +: MDPT_IDX_BITS];
    endfunction

    function automatic fetch_lane_t fetch_lane_bits(pc38_t pc);
        return pc[LANE_BITS-1:0];
    endfunction

endpackage

`default_nettype wire
